/* hw/sbt_params.svh */
`ifndef SBT_PARAMS_SVH
`define SBT_PARAMS_SVH

// data path and address width
`define SBT_DATA_W 32

// register file geometry
`define SBT_REG_ELS 32
`define SBT_REG_ADDR_W 5

// load and store immediate
`define SBT_IMM_W 12

// entries in each completion buffer
`define SBT_FIFO_DEPTH 4

`endif

/* hw/sbt_pkg.sv */
`default_nettype none

`include "sbt_params.svh"

package sbt_pkg;

  // pending classes, also the bit index inside sb_vec_t
  typedef enum logic [1:0] {
    SB_GROUP_LOAD  = 2'd0,
    SB_GLOBAL_LOAD = 2'd1,
    SB_DRAM_LOAD   = 2'd2,
    SB_LONG_OP     = 2'd3
  } sb_class_e;

  // one register's pending bits
  typedef logic [3:0] sb_vec_t;

  // decode of the instruction leaving the decode stage
  typedef struct packed {
    logic                       is_load;
    logic                       is_amo;
    logic                       write_rd;
    logic                       write_frd;
    logic                       is_idiv;
    logic                       is_fdiv_fsqrt;
    logic [`SBT_REG_ADDR_W-1:0] rd;
    logic [`SBT_DATA_W-1:0]     base;
    logic [`SBT_IMM_W-1:0]      offset;
  } issue_s;

  // marks rd pending in one class
  typedef struct packed {
    logic                       int_v;
    logic                       fp_v;
    logic [`SBT_REG_ADDR_W-1:0] rd;
    sb_class_e                  cls;
  } sb_set_s;

  typedef struct packed {
    logic [`SBT_REG_ADDR_W-1:0] rd;
    logic [`SBT_DATA_W-1:0]     data;
  } int_resp_s;

  // float results carry exception flags
  typedef struct packed {
    logic [`SBT_REG_ADDR_W-1:0] rd;
    logic [`SBT_DATA_W-1:0]     data;
    logic [4:0]                 fflags;
  } fp_resp_s;

  // single register file write port
  typedef struct packed {
    logic                       is_fp;
    logic [`SBT_REG_ADDR_W-1:0] rd;
    logic [`SBT_DATA_W-1:0]     data;
    logic [4:0]                 fflags;
  } wb_s;

  // at most one clear per file per cycle
  typedef struct packed {
    logic                       int_v;
    logic [`SBT_REG_ADDR_W-1:0] int_rd;
    logic                       fp_v;
    logic [`SBT_REG_ADDR_W-1:0] fp_rd;
  } sb_clear_s;

endpackage

`default_nettype wire

/* hw/sbt_issue_classifier.sv */
`timescale 1ns/1ns
`default_nettype none

`include "sbt_params.svh"

module sbt_issue_classifier (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             issue_v,
  input  logic             stall,
  input  logic             flush,
  input  sbt_pkg::issue_s  issue,
  output sbt_pkg::sb_set_s set
);
  import sbt_pkg::*;

  logic                   accept;
  logic [`SBT_DATA_W-1:0] eff_addr;
  logic                   region_dram;
  logic                   region_global;
  logic                   region_group;
  logic                   remote;
  logic                   int_mem;
  logic                   fp_load;
  logic                   long_op;
  sb_set_s                set_d;
  sb_set_s                set_r;

  assign accept = issue_v & ~stall & ~flush;

  // base plus sign-extended immediate
  assign eff_addr = issue.base
                  + {{(`SBT_DATA_W - `SBT_IMM_W){issue.offset[`SBT_IMM_W-1]}}, issue.offset};

  // address map regions, decoded from the top bits
  assign region_dram   = eff_addr[`SBT_DATA_W-1];
  assign region_global = (eff_addr[`SBT_DATA_W-1 -: 2] == 2'b01);
  assign region_group  = (eff_addr[`SBT_DATA_W-1 -: 3] == 3'b001);
  assign remote        = region_dram | region_global | region_group;

  // amo always returns an integer value
  assign int_mem = (issue.is_load & issue.write_rd) | issue.is_amo;
  assign fp_load = issue.is_load & issue.write_frd;
  assign long_op = issue.is_idiv | issue.is_fdiv_fsqrt;

  always_comb begin
    set_d.rd    = issue.rd;
    // long op wins over any address class
    set_d.int_v = issue.is_idiv | (int_mem & remote & ~long_op);
    set_d.fp_v  = issue.is_fdiv_fsqrt | (fp_load & remote & ~long_op);
    if (long_op) begin
      set_d.cls = SB_LONG_OP;
    end else if (region_dram) begin
      set_d.cls = SB_DRAM_LOAD;
    end else if (region_global) begin
      set_d.cls = SB_GLOBAL_LOAD;
    end else begin
      set_d.cls = SB_GROUP_LOAD;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      set_r.int_v <= 1'b0;
      set_r.fp_v  <= 1'b0;
    end else begin
      set_r.int_v <= accept & set_d.int_v;
      set_r.fp_v  <= accept & set_d.fp_v;
      if (accept) begin
        set_r.rd  <= set_d.rd;
        set_r.cls <= set_d.cls;
      end
    end
  end

  assign set = set_r;

  // a load targets exactly one register file
  a_load_one_file: assert property (@(posedge clk_i) disable iff (reset_i)
    (accept && issue.is_load) |-> !(issue.write_rd && issue.write_frd));

endmodule

`default_nettype wire

/* hw/sbt_resp_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

`include "sbt_params.svh"

module sbt_resp_fifo #(
  parameter type payload_t = logic,
  parameter int  depth     = `SBT_FIFO_DEPTH
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t head,
  output logic     not_empty,
  output logic     full
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t         mem [depth];
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w-1:0] wr_ptr;
  logic [cnt_w-1:0] count;

  // storage, written on every push
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // pointers wrap at depth, so any depth works
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign head      = mem[rd_ptr];
  assign not_empty = (count != '0);
  assign full      = (count == cnt_w'(depth));

  // producer must respect the full level
  a_no_push_full: assert property (@(posedge clk_i) disable iff (reset_i)
    push |-> !full);

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    pop |-> not_empty);

endmodule

`default_nettype wire

/* hw/sbt_writeback_merge.sv */
`timescale 1ns/1ns
`default_nettype none

module sbt_writeback_merge (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                int_not_empty,
  input  sbt_pkg::int_resp_s  int_head,
  input  logic                fp_not_empty,
  input  sbt_pkg::fp_resp_s   fp_head,
  output logic                int_pop,
  output logic                fp_pop,
  output logic                wb_v,
  output sbt_pkg::wb_s        wb,
  output sbt_pkg::sb_clear_s  clear
);
  import sbt_pkg::*;

  logic      last_int;
  logic      take_int;
  logic      take_fp;
  logic      wb_v_r;
  wb_s       wb_r;
  sb_clear_s clear_r;

  // on contention, serve the side that lost last time
  // integer goes first after reset
  assign take_int = int_not_empty & (~fp_not_empty | ~last_int);
  assign take_fp  = fp_not_empty & (~int_not_empty | last_int);

  assign int_pop = take_int;
  assign fp_pop  = take_fp;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_int      <= 1'b0;
      wb_v_r        <= 1'b0;
      clear_r.int_v <= 1'b0;
      clear_r.fp_v  <= 1'b0;
    end else begin
      if (take_int) begin
        last_int <= 1'b1;
      end else if (take_fp) begin
        last_int <= 1'b0;
      end
      wb_v_r        <= take_int | take_fp;
      clear_r.int_v <= take_int;
      clear_r.fp_v  <= take_fp;
      clear_r.int_rd <= int_head.rd;
      clear_r.fp_rd  <= fp_head.rd;
      // write payload only moves when something is popped
      if (take_int) begin
        wb_r.is_fp  <= 1'b0;
        wb_r.rd     <= int_head.rd;
        wb_r.data   <= int_head.data;
        wb_r.fflags <= '0;
      end else if (take_fp) begin
        wb_r.is_fp  <= 1'b1;
        wb_r.rd     <= fp_head.rd;
        wb_r.data   <= fp_head.data;
        wb_r.fflags <= fp_head.fflags;
      end
    end
  end

  assign wb_v  = wb_v_r;
  assign wb    = wb_r;
  assign clear = clear_r;

  // a side left waiting under contention is served next
  a_int_then_fp: assert property (@(posedge clk_i) disable iff (reset_i)
    (int_pop && fp_not_empty) |=> fp_pop);

  a_fp_then_int: assert property (@(posedge clk_i) disable iff (reset_i)
    (fp_pop && int_not_empty) |=> int_pop);

endmodule

`default_nettype wire

/* hw/sbt_pending_tracker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "sbt_params.svh"

module sbt_pending_tracker (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  sbt_pkg::sb_set_s                     set,
  input  sbt_pkg::sb_clear_s                   clear,
  output sbt_pkg::sb_vec_t [`SBT_REG_ELS-1:0]  int_sb,
  output sbt_pkg::sb_vec_t [`SBT_REG_ELS-1:0]  fp_sb
);
  import sbt_pkg::*;

  // bit layout per register
  //   [3] long op (idiv, fdiv/fsqrt)
  //   [2] remote dram load
  //   [1] remote global load
  //   [0] remote group load
  sb_vec_t [`SBT_REG_ELS-1:0] int_sb_r;
  sb_vec_t [`SBT_REG_ELS-1:0] fp_sb_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      int_sb_r <= '0;
      fp_sb_r  <= '0;
    end else begin
      // mark one class per request
      if (set.int_v) begin
        int_sb_r[set.rd][set.cls] <= 1'b1;
      end
      if (set.fp_v) begin
        fp_sb_r[set.rd][set.cls] <= 1'b1;
      end

      // clears come last so they override a set to the same register
      if (clear.int_v) begin
        int_sb_r[clear.int_rd] <= '0;
      end
      if (clear.fp_v) begin
        fp_sb_r[clear.fp_rd] <= '0;
      end
    end
  end

  assign int_sb = int_sb_r;
  assign fp_sb  = fp_sb_r;

  // a completion must match something that was marked pending
  a_int_clear_pending: assert property (@(posedge clk_i) disable iff (reset_i)
    clear.int_v |-> (int_sb_r[clear.int_rd] != '0));

  a_fp_clear_pending: assert property (@(posedge clk_i) disable iff (reset_i)
    clear.fp_v |-> (fp_sb_r[clear.fp_rd] != '0));

endmodule

`default_nettype wire

/* hw/sbt_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "sbt_params.svh"

module sbt_top (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic                                 issue_v,
  input  logic                                 stall,
  input  logic                                 flush,
  input  sbt_pkg::issue_s                      issue,
  input  logic                                 int_resp_v,
  input  sbt_pkg::int_resp_s                   int_resp,
  input  logic                                 fp_resp_v,
  input  sbt_pkg::fp_resp_s                    fp_resp,
  output logic                                 int_full,
  output logic                                 fp_full,
  output logic                                 wb_v,
  output sbt_pkg::wb_s                         wb,
  output sbt_pkg::sb_vec_t [`SBT_REG_ELS-1:0]  int_sb,
  output sbt_pkg::sb_vec_t [`SBT_REG_ELS-1:0]  fp_sb
);
  import sbt_pkg::*;

  sb_set_s   set;
  sb_clear_s clear;
  int_resp_s int_head;
  fp_resp_s  fp_head;
  logic      int_not_empty;
  logic      fp_not_empty;
  logic      int_pop;
  logic      fp_pop;

  sbt_issue_classifier u_classifier (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .issue_v (issue_v),
    .stall   (stall),
    .flush   (flush),
    .issue   (issue),
    .set     (set)
  );

  // integer completions
  sbt_resp_fifo #(.payload_t(int_resp_s)) u_int_fifo (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .push      (int_resp_v),
    .push_data (int_resp),
    .pop       (int_pop),
    .head      (int_head),
    .not_empty (int_not_empty),
    .full      (int_full)
  );

  // float completions
  sbt_resp_fifo #(.payload_t(fp_resp_s)) u_fp_fifo (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .push      (fp_resp_v),
    .push_data (fp_resp),
    .pop       (fp_pop),
    .head      (fp_head),
    .not_empty (fp_not_empty),
    .full      (fp_full)
  );

  sbt_writeback_merge u_merge (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .int_not_empty (int_not_empty),
    .int_head      (int_head),
    .fp_not_empty  (fp_not_empty),
    .fp_head       (fp_head),
    .int_pop       (int_pop),
    .fp_pop        (fp_pop),
    .wb_v          (wb_v),
    .wb            (wb),
    .clear         (clear)
  );

  sbt_pending_tracker u_tracker (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .set     (set),
    .clear   (clear),
    .int_sb  (int_sb),
    .fp_sb   (fp_sb)
  );

endmodule

`default_nettype wire

/* bench/sbt_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "sbt_params.svh"

module sbt_tb;
  import sbt_pkg::*;

  // one table row is driven for one clock
  typedef struct packed {
    logic      issue_v;
    logic      stall;
    logic      flush;
    issue_s    issue;
    logic      int_v;
    int_resp_s int_resp;
    logic      fp_v;
    fp_resp_s  fp_resp;
    logic      exp_v;
    logic      exp_fp;
    sb_class_e exp_cls;
  } step_s;

  // scoreboard event due at a given model cycle
  typedef struct packed {
    logic [31:0]                due;
    logic                       v;
    logic                       fp;
    logic [`SBT_REG_ADDR_W-1:0] rd;
    sb_class_e                  cls;
  } mark_s;

  typedef struct packed {
    logic [31:0] due;
    wb_s         wb;
  } exp_wb_s;

  localparam int k_ld = 0;
  localparam int k_fld = 1;
  localparam int k_amo = 2;
  localparam int k_idiv = 3;
  localparam int k_fdiv = 4;
  localparam int burst_int_rd [6] = '{3, 5, 7, 8, 11, 12};
  localparam int burst_fp_rd [6] = '{9, 16, 17, 18, 19, 20};

  logic                       clk_i;
  logic                       reset_i;
  logic                       issue_v;
  logic                       stall;
  logic                       flush;
  issue_s                     issue;
  logic                       int_resp_v;
  int_resp_s                  int_resp;
  logic                       fp_resp_v;
  fp_resp_s                   fp_resp;
  logic                       int_full;
  logic                       fp_full;
  logic                       wb_v;
  wb_s                        wb;
  sb_vec_t [`SBT_REG_ELS-1:0] int_sb;
  sb_vec_t [`SBT_REG_ELS-1:0] fp_sb;

  // reference model state
  step_s                      steps [$];
  int                         row_idx;
  sb_vec_t [`SBT_REG_ELS-1:0] ref_int;
  sb_vec_t [`SBT_REG_ELS-1:0] ref_fp;
  int_resp_s                  q_int [$];
  fp_resp_s                   q_fp [$];
  logic                       int_won_last;
  mark_s                      marks [$];
  mark_s                      clears [$];
  exp_wb_s                    exp_wbs [$];
  int                         cyc;
  int                         n_mismatch;
  int                         n_fail;
  logic                       saw_int_full;
  logic                       running;
  int                         idx;
  int                         waited;

  sbt_top u_sbt_top (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .issue_v    (issue_v),
    .stall      (stall),
    .flush      (flush),
    .issue      (issue),
    .int_resp_v (int_resp_v),
    .int_resp   (int_resp),
    .fp_resp_v  (fp_resp_v),
    .fp_resp    (fp_resp),
    .int_full   (int_full),
    .fp_full    (fp_full),
    .wb_v       (wb_v),
    .wb         (wb),
    .int_sb     (int_sb),
    .fp_sb      (fp_sb)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic report_failure(string msg);
    $display("ERROR t=%0t %s", $time, msg);
    n_fail = n_fail + 1;
  endtask

  task automatic check_sb(string name, sb_vec_t got, sb_vec_t exp);
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s got=%b exp=%b", $time, name, got, exp);
      n_mismatch = n_mismatch + 1;
    end
  endtask

  task automatic check_wb(wb_s got, wb_s exp);
    if (got !== exp) begin
      $display("MISMATCH t=%0t wb got=%h exp=%h", $time, got, exp);
      n_mismatch = n_mismatch + 1;
    end
  endtask

  task automatic check_full(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s got=%b exp=%b", $time, name, got, exp);
      n_mismatch = n_mismatch + 1;
    end
  endtask

  task automatic check_reg(logic [`SBT_REG_ADDR_W-1:0] rd);
    check_sb($sformatf("int_sb[%0d]", rd), int_sb[rd], ref_int[rd]);
    check_sb($sformatf("fp_sb[%0d]", rd), fp_sb[rd], ref_fp[rd]);
  endtask

  function automatic issue_s make_issue(int kind, logic [`SBT_REG_ADDR_W-1:0] rd,
                                        logic [31:0] base, logic [11:0] off);
    issue_s ins;
    ins               = '0;
    ins.rd            = rd;
    ins.base          = base;
    ins.offset        = off;
    ins.is_load       = (kind == k_ld) || (kind == k_fld);
    ins.write_rd      = (kind == k_ld) || (kind == k_amo);
    ins.write_frd     = (kind == k_fld);
    ins.is_amo        = (kind == k_amo);
    ins.is_idiv       = (kind == k_idiv);
    ins.is_fdiv_fsqrt = (kind == k_fdiv);
    return ins;
  endfunction

  task automatic add_issue(issue_s ins, logic st, logic fl, logic ev, logic efp,
                           sb_class_e ecls);
    step_s s;
    s         = '0;
    s.issue_v = 1'b1;
    s.stall   = st;
    s.flush   = fl;
    s.issue   = ins;
    s.exp_v   = ev;
    s.exp_fp  = efp;
    s.exp_cls = ecls;
    steps.push_back(s);
  endtask

  task automatic add_resp(logic iv, int_resp_s ir, logic fv, fp_resp_s fr);
    step_s s;
    s          = '0;
    s.int_v    = iv;
    s.int_resp = ir;
    s.fp_v     = fv;
    s.fp_resp  = fr;
    steps.push_back(s);
  endtask

  task automatic build_table();
    int_resp_s ir;
    fp_resp_s  fr;
    int        i;
    // integer loads per region
    // the last three cross a boundary
    add_issue(make_issue(k_ld, 1, 32'h8000_0000, 12'h000), 0, 0, 1, 0, SB_DRAM_LOAD);
    add_issue(make_issue(k_ld, 2, 32'h4000_0100, 12'h000), 0, 0, 1, 0, SB_GLOBAL_LOAD);
    add_issue(make_issue(k_ld, 3, 32'h2000_0000, 12'h000), 0, 0, 1, 0, SB_GROUP_LOAD);
    add_issue(make_issue(k_ld, 4, 32'h0000_1000, 12'h000), 0, 0, 0, 0, SB_GROUP_LOAD);
    add_issue(make_issue(k_ld, 5, 32'h4000_0004, 12'hff8), 0, 0, 1, 0, SB_GROUP_LOAD);
    add_issue(make_issue(k_ld, 6, 32'h2000_0000, 12'hffc), 0, 0, 0, 0, SB_GROUP_LOAD);
    add_issue(make_issue(k_ld, 7, 32'h8000_0002, 12'hffc), 0, 0, 1, 0, SB_GLOBAL_LOAD);
    // long ops, float load, amo
    add_issue(make_issue(k_idiv, 8, 32'h0, 12'h000), 0, 0, 1, 0, SB_LONG_OP);
    add_issue(make_issue(k_fdiv, 9, 32'h0, 12'h000), 0, 0, 1, 1, SB_LONG_OP);
    add_issue(make_issue(k_fld, 8, 32'h8000_0000, 12'h000), 0, 0, 1, 1, SB_DRAM_LOAD);
    add_issue(make_issue(k_amo, 11, 32'h4000_0000, 12'h000), 0, 0, 1, 0, SB_GLOBAL_LOAD);
    add_issue(make_issue(k_idiv, 12, 32'h8000_0000, 12'h000), 0, 0, 1, 0, SB_LONG_OP);
    // stall and flush drop the issue
    add_issue(make_issue(k_ld, 13, 32'h8000_0000, 12'h000), 1, 0, 0, 0, SB_GROUP_LOAD);
    add_issue(make_issue(k_ld, 14, 32'h8000_0000, 12'h000), 0, 1, 0, 0, SB_GROUP_LOAD);
    for (i = 0; i < 5; i++) begin
      add_issue(make_issue(k_fld, `SBT_REG_ADDR_W'(16 + i), 32'h4000_0000 + 16 * i, 12'h0),
                0, 0, 1, 1, SB_GLOBAL_LOAD);
    end
    // single completions, then a set landing with a clear
    add_resp(1'b1, int_resp_s'{5'd1, 32'hdead_beef}, 1'b0, '0);
    add_resp(1'b0, '0, 1'b1, fp_resp_s'{5'd8, 32'h3f80_0000, 5'b00101});
    add_resp(1'b1, int_resp_s'{5'd2, 32'h0bad_f00d}, 1'b0, '0);
    add_issue(make_issue(k_ld, 2, 32'h8000_0000, 12'h000), 0, 0, 1, 0, SB_DRAM_LOAD);
    // both sides every cycle until the integer buffer fills
    for (i = 0; i < 6; i++) begin
      ir.rd     = `SBT_REG_ADDR_W'(burst_int_rd[i]);
      ir.data   = 32'h1000_0000 + i;
      fr.rd     = `SBT_REG_ADDR_W'(burst_fp_rd[i]);
      fr.data   = 32'h4000_0000 + i;
      fr.fflags = 5'(i + 1);
      add_resp(1'b1, ir, 1'b1, fr);
    end
  endtask

  task automatic drive_step(int n);
    row_idx    <= n;
    issue_v    <= steps[n].issue_v;
    stall      <= steps[n].stall;
    flush      <= steps[n].flush;
    issue      <= steps[n].issue;
    int_resp_v <= steps[n].int_v;
    int_resp   <= steps[n].int_resp;
    fp_resp_v  <= steps[n].fp_v;
    fp_resp    <= steps[n].fp_resp;
  endtask

  function automatic logic model_idle();
    return q_int.size() == 0 && q_fp.size() == 0 && exp_wbs.size() == 0
           && marks.size() == 0 && clears.size() == 0;
  endfunction

  // one model step per falling edge mirrors the state after the last rising edge
  task automatic model_cycle();
    step_s                      s;
    mark_s                      m;
    exp_wb_s                    e;
    int_resp_s                  ir;
    fp_resp_s                   fr;
    logic                       take_int;
    logic                       take_fp;
    logic                       chk_set;
    logic [`SBT_REG_ADDR_W-1:0] set_rd;
    cyc = cyc + 1;
    check_full("int_full", int_full, q_int.size() == `SBT_FIFO_DEPTH);
    check_full("fp_full", fp_full, q_fp.size() == `SBT_FIFO_DEPTH);
    if (int_full) begin
      saw_int_full = 1'b1;
    end
    if (exp_wbs.size() != 0 && exp_wbs[0].due == cyc) begin
      e = exp_wbs.pop_front();
      if (!wb_v) begin
        report_failure("wb_v stayed low when a write-back was due");
      end else begin
        check_wb(wb, e.wb);
        m     = '0;
        m.due = cyc + 1;
        m.fp  = e.wb.is_fp;
        m.rd  = e.wb.rd;
        clears.push_back(m);
      end
    end else if (wb_v) begin
      report_failure("wb_v rose with no write-back due");
    end
    // sets go in before clears so a clear wins on the same register
    chk_set = 1'b0;
    set_rd  = '0;
    if (marks.size() != 0 && marks[0].due == cyc) begin
      m = marks.pop_front();
      if (m.v && m.fp) begin
        ref_fp[m.rd][m.cls] = 1'b1;
      end else if (m.v) begin
        ref_int[m.rd][m.cls] = 1'b1;
      end
      chk_set = 1'b1;
      set_rd  = m.rd;
    end
    if (clears.size() != 0 && clears[0].due == cyc) begin
      m = clears.pop_front();
      if (m.fp) begin
        ref_fp[m.rd] = '0;
      end else begin
        ref_int[m.rd] = '0;
      end
      check_reg(m.rd);
    end
    if (chk_set) begin
      check_reg(set_rd);
    end
    // alternating pick with integer first after reset
    take_int = q_int.size() != 0 && (q_fp.size() == 0 || !int_won_last);
    take_fp  = q_fp.size() != 0 && !take_int;
    e.due    = cyc + 1;
    if (take_int) begin
      ir           = q_int.pop_front();
      e.wb         = '{1'b0, ir.rd, ir.data, 5'd0};
      int_won_last = 1'b1;
      exp_wbs.push_back(e);
    end else if (take_fp) begin
      fr           = q_fp.pop_front();
      e.wb         = '{1'b1, fr.rd, fr.data, fr.fflags};
      int_won_last = 1'b0;
      exp_wbs.push_back(e);
    end
    // inputs seen now enter the DUT at the next rising edge
    if (int_resp_v) begin
      q_int.push_back(int_resp);
    end
    if (fp_resp_v) begin
      q_fp.push_back(fp_resp);
    end
    if (issue_v) begin
      s     = steps[row_idx];
      m     = '0;
      m.due = cyc + 2;
      m.v   = s.exp_v;
      m.fp  = s.exp_fp;
      m.rd  = s.issue.rd;
      m.cls = s.exp_cls;
      marks.push_back(m);
    end
  endtask

  always @(negedge clk_i) begin
    if (running) begin
      model_cycle();
    end
  end

  initial begin
    reset_i      = 1'b1;
    issue_v      = 1'b0;
    stall        = 1'b0;
    flush        = 1'b0;
    issue        = '0;
    int_resp_v   = 1'b0;
    int_resp     = '0;
    fp_resp_v    = 1'b0;
    fp_resp      = '0;
    row_idx      = 0;
    ref_int      = '0;
    ref_fp       = '0;
    int_won_last = 1'b0;
    cyc          = 0;
    n_mismatch   = 0;
    n_fail       = 0;
    saw_int_full = 1'b0;
    running      = 1'b0;
    build_table();
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;
    running <= 1'b1;
    for (idx = 0; idx < steps.size(); idx++) begin
      @(posedge clk_i);
      drive_step(idx);
    end
    @(posedge clk_i);
    issue_v    <= 1'b0;
    int_resp_v <= 1'b0;
    fp_resp_v  <= 1'b0;
    // drain the buffers and the pending clears
    waited = 0;
    while (!model_idle() && waited < 64) begin
      @(posedge clk_i);
      waited = waited + 1;
    end
    if (!model_idle()) begin
      report_failure("timeout: write-backs did not drain within 64 cycles");
    end
    if (!saw_int_full) begin
      report_failure("integer buffer never reported full");
    end
    $display("summary: %0d mismatches, %0d other errors", n_mismatch, n_fail);
    if (n_mismatch == 0 && n_fail == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+hw
hw/sbt_pkg.sv
hw/sbt_issue_classifier.sv
hw/sbt_resp_fifo.sv
hw/sbt_writeback_merge.sv
hw/sbt_pending_tracker.sv
hw/sbt_top.sv
bench/sbt_tb.sv
